// ==== Bender.yml ====
package:
  name: risc_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/stage_if.sv
      - logic/reg_file.sv
      - logic/fetch_decode.sv
      - logic/alu_execute.sv
      - logic/writeback.sv
      - logic/risc_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/risc_core_props.sv
      - sim/tb_risc_core.sv

// ==== logic/alu_execute.sv ====
// operand forwarding, ALU, load/store address and the data bus register
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module alu_execute (
    input  logic                     CLK,
    input  logic                     RSTN,
    exec_if.sink                     ex,
    res_if.src                       rs,
    output logic                     DREQ,
    output logic                     DRW,
    output logic [`RISC_IADDR_W-1:0] DADDR,
    output logic [`RISC_XLEN-1:0]    DWDATA,
    input  logic [`RISC_XLEN-1:0]    DRDATA
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_t                sel_b;
    fwd_sel_t                sel_c;
    logic [`RISC_XLEN-1:0]   ex_val;     // what the execute register will write
    logic [`RISC_XLEN-1:0]   opb;
    logic [`RISC_XLEN-1:0]   opc;
    logic [`RISC_XLEN-1:0]   st_data;
    logic [`RISC_XLEN-1:0]   addr;
    logic [`RISC_XLEN-1:0]   alu_out;
    logic [2*`RISC_XLEN-1:0] rot;
    logic [SHAMT_W-1:0]      amt;
    logic                    is_mem;

    // youngest writer wins
    function automatic fwd_sel_t route(
        input logic                    used,
        input logic [`RISC_REG_AW-1:0] idx,
        input logic                    ex_wr,
        input logic [`RISC_REG_AW-1:0] ex_dst,
        input logic                    wb_wr,
        input logic [`RISC_REG_AW-1:0] wb_dst
    );
        if (used && ex_wr && (ex_dst == idx)) begin
            return FWD_EX;
        end
        if (used && wb_wr && (wb_dst == idx)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    function automatic logic [`RISC_XLEN-1:0] pick(
        input fwd_sel_t              sel,
        input logic [`RISC_XLEN-1:0] rf_val,
        input logic [`RISC_XLEN-1:0] ex_fwd,
        input logic [`RISC_XLEN-1:0] wb_fwd
    );
        case (sel)
            FWD_EX:  return ex_fwd;
            FWD_WB:  return wb_fwd;
            default: return rf_val;
        endcase
    endfunction

    ////////////////////
    // forwarding
    ////////////////////

    assign ex_val = (rs.valid && is_load(rs.op)) ? DRDATA : rs.res;   // load data this cycle
    assign sel_b  = route(reads_rb(ex.op), ex.src_b, rs.wr, rs.dst, rs.wb_wr, rs.wb_dst);
    assign sel_c  = route(reads_rc(ex.op) || is_store(ex.op), ex.src_c,
                          rs.wr, rs.dst, rs.wb_wr, rs.wb_dst);

    assign opb     = pick(sel_b, ex.b_val, ex_val, rs.wb_res);
    assign opc     = pick(sel_c, ex.c_val, ex_val, rs.wb_res);
    assign st_data = pick(sel_c, ex.st_val, ex_val, rs.wb_res);

    ////////////////////
    // alu
    ////////////////////

    assign amt    = ex.sh_reg ? opc[SHAMT_W-1:0] : ex.imm[SHAMT_W-1:0];   // mod 32
    assign rot    = {opb, opb} >> amt;
    assign is_mem = is_load(ex.op) || is_store(ex.op);
    assign addr   = (ex.src_b == `RISC_REG_AW'(`RISC_ABS_BASE)) ? ex.imm : ex.imm + opb;

    always_comb begin
        case (ex.op)
            OP_ADDI: alu_out = opb + ex.imm;
            OP_ANDI: alu_out = opb & ex.imm;
            OP_ORI:  alu_out = opb | ex.imm;
            OP_MOVI: alu_out = ex.imm;
            OP_ADD:  alu_out = opb + opc;
            OP_SUB:  alu_out = opb - opc;
            OP_NEG:  alu_out = '0 - opc;
            OP_NOT:  alu_out = ~opc;
            OP_AND:  alu_out = opb & opc;
            OP_OR:   alu_out = opb | opc;
            OP_XOR:  alu_out = opb ^ opc;
            OP_LSR:  alu_out = opb >> amt;
            OP_ASR:  alu_out = $signed(opb) >>> amt;
            OP_SHL:  alu_out = opb << amt;
            OP_ROR:  alu_out = rot[`RISC_XLEN-1:0];
            OP_LD, OP_ST: alu_out = addr;                // byte address
            default: alu_out = '0;                       // unknown op, no effect
        endcase
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            rs.valid <= 1'b0;
            rs.wr    <= 1'b0;
            DREQ     <= 1'b0;
            DRW      <= 1'b0;
        end else begin
            rs.valid <= ex.valid;
            rs.wr    <= ex.valid && writes_ra(ex.op);
            DREQ     <= ex.valid && is_mem;
            DRW      <= ex.valid && is_store(ex.op);
        end
    end

    always_ff @(posedge CLK) begin
        rs.op  <= ex.op;
        rs.dst <= ex.dst;
        rs.res <= alu_out;
        DWDATA <= st_data;
    end

    assign DADDR = rs.res[`RISC_XLEN-1:2];        // word address

endmodule

`default_nettype wire

// ==== logic/fetch_decode.sv ====
// fetch PC and fetch register, register read and immediate forming
// result registered onto exec_if
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module fetch_decode (
    input  logic                     CLK,
    input  logic                     RSTN,
    output logic                     IREQ,
    output logic [`RISC_IADDR_W-1:0] IADDR,
    input  isa_pkg::instr_t          INSTR,
    output logic [`RISC_REG_AW-1:0]  rf_ra0,
    output logic [`RISC_REG_AW-1:0]  rf_ra1,
    input  logic [`RISC_XLEN-1:0]    rf_rd0,
    input  logic [`RISC_XLEN-1:0]    rf_rd1,
    exec_if.src                      ex
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic                  f_valid;    // fetch register holds an instruction
    instr_t                f_instr;
    opcode_t               f_op;
    logic                  f_store;
    logic [`RISC_XLEN-1:0] imm;

    ////////////////////
    // fetch
    ////////////////////

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            IREQ  <= 1'b0;
            IADDR <= '0;
        end else begin
            IREQ <= 1'b1;                          // fetch every cycle, no branches
            if (IREQ) begin
                IADDR <= IADDR + 1'b1;             // next word
            end
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            f_valid <= 1'b0;
            f_instr <= '0;
        end else begin
            f_valid <= IREQ;
            if (IREQ) begin
                f_instr <= INSTR;
            end
        end
    end

    ////////////////////
    // decode
    ////////////////////

    assign f_op    = f_instr.r.op;
    assign f_store = is_store(f_op);
    assign rf_ra0  = f_instr.r.rb;
    assign rf_ra1  = reads_rc(f_op) ? f_instr.r.rc : f_instr.r.ra;   // ra for store data

    always_comb begin
        case (f_op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_MOVI:
                imm = {{(`RISC_XLEN-IMM_W){f_instr.i.imm[IMM_W-1]}}, f_instr.i.imm};
            OP_LD, OP_ST:
                imm = {{(`RISC_XLEN-IMM_W){1'b0}}, f_instr.i.imm};        // unsigned offset
            OP_LSR, OP_ASR, OP_SHL, OP_ROR:
                imm = f_instr.r.sh_reg ? '0
                                       : {{(`RISC_XLEN-SHAMT_W){1'b0}}, f_instr.r.shamt};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= f_valid;
        end
    end

    always_ff @(posedge CLK) begin
        ex.op     <= f_op;
        ex.dst    <= f_instr.r.ra;
        ex.src_b  <= rf_ra0;
        ex.src_c  <= rf_ra1;
        ex.b_val  <= rf_rd0;
        ex.c_val  <= f_store ? '0 : rf_rd1;        // alu side quiet on stores
        ex.st_val <= f_store ? rf_rd1 : '0;
        ex.imm    <= imm;
        ex.sh_reg <= f_instr.r.sh_reg;
    end

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
// instruction set: opcode values and the instruction word layouts
`default_nettype none
`include "risc_defs.svh"

package isa_pkg;

    localparam int OP_W    = 5;                          // opcode field
    localparam int SHAMT_W = $clog2(`RISC_XLEN);         // shift amount field
    localparam int IMM_W   = `RISC_XLEN - OP_W - 2*`RISC_REG_AW;              // 17
    localparam int SPARE_W = `RISC_XLEN - OP_W - 3*`RISC_REG_AW - 1 - SHAMT_W; // 6

    typedef logic [OP_W-1:0] opcode_t;

    ////////////////////
    // opcodes
    ////////////////////
    localparam opcode_t OP_ADDI = 5'd0;
    localparam opcode_t OP_ANDI = 5'd1;
    localparam opcode_t OP_ORI  = 5'd2;
    localparam opcode_t OP_MOVI = 5'd3;
    localparam opcode_t OP_ADD  = 5'd4;
    localparam opcode_t OP_SUB  = 5'd5;
    localparam opcode_t OP_NEG  = 5'd6;
    localparam opcode_t OP_NOT  = 5'd7;
    localparam opcode_t OP_AND  = 5'd8;
    localparam opcode_t OP_OR   = 5'd9;
    localparam opcode_t OP_XOR  = 5'd10;
    localparam opcode_t OP_LSR  = 5'd11;
    localparam opcode_t OP_ASR  = 5'd12;
    localparam opcode_t OP_SHL  = 5'd13;
    localparam opcode_t OP_ROR  = 5'd14;
    localparam opcode_t OP_LD   = 5'd19;
    localparam opcode_t OP_ST   = 5'd21;

    typedef struct packed {
        opcode_t                 op;
        logic [`RISC_REG_AW-1:0] ra;       // destination
        logic [`RISC_REG_AW-1:0] rb;
        logic [`RISC_REG_AW-1:0] rc;
        logic [SPARE_W-1:0]      spare;
        logic                    sh_reg;   // shift amount from rc
        logic [SHAMT_W-1:0]      shamt;
    } rform_t;

    typedef struct packed {
        opcode_t                 op;
        logic [`RISC_REG_AW-1:0] ra;       // destination or store data
        logic [`RISC_REG_AW-1:0] rb;       // source or address base
        logic [IMM_W-1:0]        imm;
    } iform_t;

    // same 32 bits, read either way by decode
    typedef union packed {
        rform_t r;
        iform_t i;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
// pipeline control: forwarding source codes and opcode classification
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // operand source picked in execute
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_RF = 2'd0;   // value read from register file
    localparam fwd_sel_t FWD_EX = 2'd1;   // execute register result
    localparam fwd_sel_t FWD_WB = 2'd2;   // writeback register result

    function automatic logic reads_rb(input opcode_t op);
        case (op)
            OP_ADDI, OP_ANDI, OP_ORI,
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_LSR, OP_ASR, OP_SHL, OP_ROR,
            OP_LD, OP_ST: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    // second read port holds rc for these, ra for the rest
    function automatic logic reads_rc(input opcode_t op);
        case (op)
            OP_ADD, OP_SUB, OP_NEG, OP_NOT, OP_AND, OP_OR, OP_XOR,
            OP_LSR, OP_ASR, OP_SHL, OP_ROR: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

    function automatic logic writes_ra(input opcode_t op);
        return (op <= OP_ROR) || (op == OP_LD);   // unknown ops write nothing
    endfunction

    function automatic logic is_load(input opcode_t op);
        return op == OP_LD;
    endfunction

    function automatic logic is_store(input opcode_t op);
        return op == OP_ST;
    endfunction

endpackage

`default_nettype wire

// ==== logic/reg_file.sv ====
// general purpose register file, two read ports, one write port
// a write in flight is visible on the read ports in the same cycle
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module reg_file (
    input  logic                    CLK,
    input  logic                    RSTN,
    input  logic                    wen,
    input  logic [`RISC_REG_AW-1:0] wa,
    input  logic [`RISC_XLEN-1:0]   wd,
    input  logic [`RISC_REG_AW-1:0] ra0,
    input  logic [`RISC_REG_AW-1:0] ra1,
    output logic [`RISC_XLEN-1:0]   rd0,
    output logic [`RISC_XLEN-1:0]   rd1
);

    logic [`RISC_XLEN-1:0] regs [`RISC_NREGS];

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            for (int i = 0; i < `RISC_NREGS; i++) begin
                regs[i] <= '0;                      // all registers start at zero
            end
        end else if (wen) begin
            regs[wa] <= wd;
        end
    end

    ////////////////////
    // read with bypass
    ////////////////////

    // covers the writer three slots ahead of decode
    assign rd0 = (wen && (wa == ra0)) ? wd : regs[ra0];
    assign rd1 = (wen && (wa == ra1)) ? wd : regs[ra1];

endmodule

`default_nettype wire

// ==== logic/risc_core.sv ====
// core top: four stage pipeline, instruction and data bus ports
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module risc_core (
    input  logic                     CLK,
    input  logic                     RSTN,
    output logic                     IREQ,
    output logic [`RISC_IADDR_W-1:0] IADDR,
    input  logic [`RISC_XLEN-1:0]    INSTR,
    output logic                     DREQ,
    output logic                     DRW,
    output logic [`RISC_IADDR_W-1:0] DADDR,
    output logic [`RISC_XLEN-1:0]    DWDATA,
    input  logic [`RISC_XLEN-1:0]    DRDATA
);

    exec_if ex_bus ();    // decode -> execute
    res_if  res_bus ();   // execute <-> writeback

    logic                    rf_wen;
    logic [`RISC_REG_AW-1:0] rf_wa;
    logic [`RISC_XLEN-1:0]   rf_wd;
    logic [`RISC_REG_AW-1:0] rf_ra0;
    logic [`RISC_REG_AW-1:0] rf_ra1;
    logic [`RISC_XLEN-1:0]   rf_rd0;
    logic [`RISC_XLEN-1:0]   rf_rd1;

    reg_file reg_file_i (
        .CLK  (CLK),
        .RSTN (RSTN),
        .wen  (rf_wen),
        .wa   (rf_wa),
        .wd   (rf_wd),
        .ra0  (rf_ra0),
        .ra1  (rf_ra1),
        .rd0  (rf_rd0),
        .rd1  (rf_rd1)
    );

    fetch_decode fetch_decode_i (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .IREQ   (IREQ),
        .IADDR  (IADDR),
        .INSTR  (INSTR),
        .rf_ra0 (rf_ra0),
        .rf_ra1 (rf_ra1),
        .rf_rd0 (rf_rd0),
        .rf_rd1 (rf_rd1),
        .ex     (ex_bus)
    );

    alu_execute alu_execute_i (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .ex     (ex_bus),
        .rs     (res_bus),
        .DREQ   (DREQ),
        .DRW    (DRW),
        .DADDR  (DADDR),
        .DWDATA (DWDATA),
        .DRDATA (DRDATA)
    );

    writeback writeback_i (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .rs     (res_bus),
        .DRDATA (DRDATA),
        .wen    (rf_wen),
        .wa     (rf_wa),
        .wd     (rf_wd)
    );

endmodule

`default_nettype wire

// ==== logic/risc_defs.svh ====
// word, register file and bus address widths of the core
// plus the base register index that selects absolute addressing

`ifndef RISC_DEFS_SVH
`define RISC_DEFS_SVH

////////////////////
// datapath
////////////////////

`define RISC_XLEN      32   // data word width
`define RISC_REG_AW    5    // register index width
`define RISC_NREGS     32   // register file depth

////////////////////
// memory buses
////////////////////

`define RISC_IADDR_W   30   // word address, both buses

// LD/ST with this base register use the bare immediate
`define RISC_ABS_BASE  31

`endif

// ==== logic/stage_if.sv ====
// stage buses: decode to execute (exec_if), execute to writeback (res_if)
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

interface exec_if;
    import isa_pkg::*;

    logic                    valid;
    opcode_t                 op;
    logic [`RISC_REG_AW-1:0] dst;      // ra
    logic [`RISC_REG_AW-1:0] src_b;    // rb index
    logic [`RISC_REG_AW-1:0] src_c;    // rc or ra index
    logic [`RISC_XLEN-1:0]   b_val;    // rb value
    logic [`RISC_XLEN-1:0]   c_val;    // rc/ra value, alu side
    logic [`RISC_XLEN-1:0]   imm;      // formed immediate
    logic                    sh_reg;   // shift amount from rc
    logic [`RISC_XLEN-1:0]   st_val;   // ra value, store side

    modport src  (output valid, op, dst, src_b, src_c, b_val, c_val, imm, sh_reg, st_val);
    modport sink (input  valid, op, dst, src_b, src_c, b_val, c_val, imm, sh_reg, st_val);
endinterface

interface res_if;
    import isa_pkg::*;

    logic                    valid;
    opcode_t                 op;
    logic [`RISC_REG_AW-1:0] dst;
    logic                    wr;       // valid and writes ra
    logic [`RISC_XLEN-1:0]   res;      // alu result or byte address
    logic [`RISC_XLEN-1:0]   wb_res;   // back from writeback
    logic [`RISC_REG_AW-1:0] wb_dst;
    logic                    wb_wr;

    modport src  (output valid, op, dst, wr, res, input  wb_res, wb_dst, wb_wr);
    modport sink (input  valid, op, dst, wr, res, output wb_res, wb_dst, wb_wr);
endinterface

`default_nettype wire

// ==== logic/writeback.sv ====
// writeback register: load data or alu result, register file write port
// and the fields returned to execute for forwarding
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module writeback (
    input  logic                    CLK,
    input  logic                    RSTN,
    res_if.sink                     rs,
    input  logic [`RISC_XLEN-1:0]   DRDATA,
    output logic                    wen,
    output logic [`RISC_REG_AW-1:0] wa,
    output logic [`RISC_XLEN-1:0]   wd
);

    import pipe_pkg::*;

    logic                    ld_sel;     // take the data bus this cycle
    logic                    wb_wr;
    logic [`RISC_REG_AW-1:0] wb_dst;
    logic [`RISC_XLEN-1:0]   wb_res;

    assign ld_sel = rs.valid && is_load(rs.op);

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wb_wr <= 1'b0;
        end else begin
            wb_wr <= rs.wr;
        end
    end

    always_ff @(posedge CLK) begin
        wb_dst <= rs.dst;
        wb_res <= ld_sel ? DRDATA : rs.res;
    end

    ////////////////////
    // outputs
    ////////////////////

    // register file, written at the next edge
    assign wen = wb_wr;
    assign wa  = wb_dst;
    assign wd  = wb_res;

    // forwarding path back to execute
    assign rs.wb_wr  = wb_wr;
    assign rs.wb_dst = wb_dst;
    assign rs.wb_res = wb_res;

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_if.sv
logic/reg_file.sv
logic/fetch_decode.sv
logic/alu_execute.sv
logic/writeback.sv
logic/risc_core.sv
sim/risc_core_props.sv
sim/tb_risc_core.sv

// ==== sim/program_stimulus.hex ====
// words 0..31 program, 32..47 data memory preload, 48 store count,
// then one line per store: word address (DADDR), data (DWDATA)
// immediate arithmetic, absolute stores, load then dependent ADD
18400123 0083FFFF 08C200F0 11030000
A8BE0020 A8FE0024 A93E0028 997E0000
// register arithmetic, base plus offset store
218A1000 29CC5000 32007000 3A408000
428C4000 4AD42000 53165000 AA460010
// shifts by shamt and by register, amounts 4, 31, 0, 31
AB3E002C 1B40001F 5B8A0004 63CAD020
6C0A0000 744AD020 ABBE0034 ABFE0038
// unknown opcodes 16 and 20, load of a stored word, forwarded store
AC3E003C AC460000 838A1234 A07E0024
ABBE0030 9C860004 04E40001 ACFE0028
// data memory preload
89ABCDEF 5A5A0001 5A5A0002 5A5A0003
5A5A0004 5A5A0005 5A5A0006 5A5A0007
5A5A0008 5A5A0009 5A5A000A 5A5A000B
5A5A000C 5A5A000D 5A5A000E 5A5A000F
// expected stores
0000000B
00000008 00000122
00000009 00000020
0000000A FFFF0123
0000000C 00000122
0000000B 0000CCCD
0000000D 089ABCDE
0000000E FFFFFFFF
0000000F 89ABCDEF
00000008 13579BDF
0000000C 089ABCDE
0000000A 00000021

// ==== sim/risc_core_props.sv ====
// concurrent checks on the core's bus ports, bound into risc_core
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module risc_core_props (
    input logic                     CLK,
    input logic                     RSTN,
    input logic                     IREQ,
    input logic [`RISC_IADDR_W-1:0] IADDR,
    input logic                     DREQ,
    input logic                     DRW,
    input logic [`RISC_IADDR_W-1:0] DADDR
);

    // write strobe only inside a request
    a_drw_in_req: assert property (@(posedge CLK) disable iff (!RSTN) DRW |-> DREQ)
        else $error("DRW high while DREQ low");

    a_dbus_known: assert property (@(posedge CLK) disable iff (!RSTN) !$isunknown({DREQ, DADDR}))
        else $error("DREQ or DADDR unknown");

    // sequential fetch, one word per cycle
    a_iaddr_step: assert property (@(posedge CLK) disable iff (!RSTN)
        IREQ |=> (IADDR == $past(IADDR) + 1'b1))
        else $error("IADDR did not step by one");

endmodule

bind risc_core risc_core_props risc_core_props_i (
    .CLK   (CLK),
    .RSTN  (RSTN),
    .IREQ  (IREQ),
    .IADDR (IADDR),
    .DREQ  (DREQ),
    .DRW   (DRW),
    .DADDR (DADDR)
);

`default_nettype wire

// ==== sim/tb_risc_core.sv ====
// testbench for the core: clock and reset, instruction and data memory models,
// store record checking against the stimulus file
`timescale 1ns/1ps
`default_nettype none
`include "risc_defs.svh"

module tb_risc_core;

    localparam int PROG_WORDS    = 32;                   // instruction memory depth
    localparam int DATA_WORDS    = 16;                   // data memory depth
    localparam int MAX_STORES    = 11;
    localparam int COUNT_POS     = PROG_WORDS + DATA_WORDS;
    localparam int REC_BASE      = COUNT_POS + 1;        // first addr/data pair
    localparam int STIM_WORDS    = REC_BASE + 2*MAX_STORES;
    localparam int RESET_CYCLES  = 8;
    localparam int STORE_TIMEOUT = 200;                  // cycles
    localparam int DRAIN_TIMEOUT = 100;
    localparam int DRAIN_ADDR    = 48;                   // fetch well past the program
    localparam logic [`RISC_XLEN-1:0] NOP_WORD = 32'hF800_0000;   // opcode 31, unused

    logic                     CLK;
    logic                     RSTN;
    logic                     IREQ;
    logic [`RISC_IADDR_W-1:0] IADDR;
    logic [`RISC_XLEN-1:0]    INSTR;
    logic                     DREQ;
    logic                     DRW;
    logic [`RISC_IADDR_W-1:0] DADDR;
    logic [`RISC_XLEN-1:0]    DWDATA;
    logic [`RISC_XLEN-1:0]    DRDATA;

    logic [`RISC_XLEN-1:0]    stim [STIM_WORDS];     // whole stimulus file
    logic [`RISC_XLEN-1:0]    dmem [DATA_WORDS];
    logic [`RISC_IADDR_W-1:0] next_pc;               // expected IADDR
    int                       store_count;
    int                       store_idx;
    int                       cycles;

    risc_core risc_core_i (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .IREQ   (IREQ),
        .IADDR  (IADDR),
        .INSTR  (INSTR),
        .DREQ   (DREQ),
        .DRW    (DRW),
        .DADDR  (DADDR),
        .DWDATA (DWDATA),
        .DRDATA (DRDATA)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;                            // 10 ns period

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // words past the program read as no-ops
    function automatic logic [`RISC_XLEN-1:0] fetch_word(input logic [`RISC_IADDR_W-1:0] addr);
        if (addr < PROG_WORDS) begin
            return stim[int'(addr)];
        end
        return NOP_WORD;
    endfunction

    // data bus, sampled mid cycle where it is stable
    task automatic serve_data();
        if (DREQ === 1'b1) begin
            if (DADDR >= DATA_WORDS) begin
                stop_with_error("data request outside the data memory");
            end else if (DRW === 1'b1) begin
                if (store_idx >= store_count) begin
                    stop_with_error("store seen after all expected stores");
                end else begin
                    check_value("DADDR", DADDR, stim[REC_BASE + 2*store_idx]);
                    check_value("DWDATA", DWDATA, stim[REC_BASE + 2*store_idx + 1]);
                    dmem[int'(DADDR)] = DWDATA;          // lands at the closing edge
                    store_idx++;
                end
            end else begin
                DRDATA = dmem[int'(DADDR)];              // load answer
            end
        end
    endtask

    // one cycle after reset: fetch check, data bus, next instruction
    task automatic run_cycle();
        @(negedge CLK);
        check_value("IREQ", IREQ, 1);
        check_value("IADDR", IADDR, next_pc);
        next_pc = next_pc + 1'b1;
        serve_data();
        INSTR = fetch_word(IADDR);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        RSTN      = 1'b0;
        INSTR     = NOP_WORD;
        DRDATA    = '0;
        next_pc   = '0;
        store_idx = 0;
        $readmemh("sim/program_stimulus.hex", stim);
        if ($isunknown(stim[STIM_WORDS-1])) begin
            stop_with_error("stimulus file missing or too short");
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = stim[PROG_WORDS + i];              // data preload
        end
        store_count = int'(stim[COUNT_POS]);
        if (store_count > MAX_STORES) begin
            stop_with_error("stimulus file holds more store records than expected");
        end

        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_value("IREQ", IREQ, 0);                // quiet buses in reset
            check_value("DREQ", DREQ, 0);
            check_value("DRW", DRW, 0);
        end
        RSTN = 1'b1;

        cycles = 0;
        while (store_idx < store_count) begin
            if (cycles == STORE_TIMEOUT) begin
                stop_with_error("timed out waiting for the expected stores");
            end
            run_cycle();
            cycles++;
        end

        // run on past the program, no further stores allowed
        cycles = 0;
        while (next_pc < DRAIN_ADDR) begin
            if (cycles == DRAIN_TIMEOUT) begin
                stop_with_error("timed out waiting for the fetch address to pass the program");
            end
            run_cycle();
            cycles++;
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
